// File: dmix_config.svh
// frame FIFO depth, bit-clock divider, volume format and register offsets
`ifndef DMIX_CONFIG_SVH
`define DMIX_CONFIG_SVH

// stereo frames held between input pairing and the mixer
`define DMIX_FIFO_DEPTH 4

// clk491520 cycles per bck period, 32 bck per channel
`define DMIX_BCK_DIV 8

// unsigned Q8.24 volume
`define DMIX_VOL_WIDTH 32
`define DMIX_VOL_FRAC 24

// APB register offsets
`define DMIX_REG_VOL_L 4'h0
`define DMIX_REG_VOL_R 4'h4
`define DMIX_REG_CTRL 4'h8
`define DMIX_REG_STATUS 4'hC

`endif

// File: dmix_pkg.sv
// shared types: sample, stereo frame, APB request/response, volume config, status, register map
package dmix_pkg;

    `include "dmix_config.svh"

    // one decoded PCM word, lrck high for the right channel
    typedef struct packed {
        logic signed [23:0] word;
        logic               lrck;
    } sample_t;

    // valid low when the FIFO had nothing to give
    typedef struct packed {
        logic               valid;
        logic signed [23:0] left;
        logic signed [23:0] right;
    } frame_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [`DMIX_VOL_WIDTH-1:0] vol_l;
        logic [`DMIX_VOL_WIDTH-1:0] vol_r;
        logic                       mute;
    } vol_cfg_t;

    // bit order matches the STATUS register
    typedef struct packed {
        logic underrun;
        logic overflow;
    } dmix_status_t;

    typedef enum logic [3:0] {
        VOL_L  = `DMIX_REG_VOL_L,
        VOL_R  = `DMIX_REG_VOL_R,
        CTRL   = `DMIX_REG_CTRL,
        STATUS = `DMIX_REG_STATUS
    } reg_addr_e;

endpackage

// File: frame_fifo.sv
// frame FIFO with left/right pairing, circular buffer and pop/ack read side
`timescale 1ns/1ns
`include "dmix_config.svh"

module frame_fifo
    import dmix_pkg::*;
(
    input  logic    clk491520,
    input  logic    rst_ip,
    input  logic    in_ack_i,
    input  sample_t in_sample_i,
    input  logic    pop_i,
    output logic    ack_o,
    output frame_t  frame_o,
    output logic    ovf_o,
    output logic    unf_o
);
    localparam int DEPTH = `DMIX_FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;

    logic [47:0]        mem [DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [CW-1:0]      count;
    logic signed [23:0] left_q;
    logic               left_vld_q;
    logic               push;
    logic               full;
    logic               empty;
    logic               do_push;
    logic               do_pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // right word completes a frame only after a left
    assign push = in_ack_i && in_sample_i.lrck && left_vld_q;
    assign full = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign do_push = push && !full;
    assign do_pop = pop_i && !empty;

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            left_vld_q <= 1'b0;
        end else if (in_ack_i) begin
            left_vld_q <= !in_sample_i.lrck;
        end
    end

    always_ff @(posedge clk491520) begin
        if (in_ack_i && !in_sample_i.lrck) begin
            left_q <= in_sample_i.word;
        end
        if (do_push) begin
            mem[wr_ptr] <= {left_q, in_sample_i.word};
        end
        // empty FIFO still answers with an invalid silent frame
        if (pop_i) begin
            frame_o <= empty ? '0 : {1'b1, mem[rd_ptr]};
        end
    end

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            ack_o <= 1'b0;
            ovf_o <= 1'b0;
            unf_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CW'(do_push) - CW'(do_pop);
            ack_o <= pop_i;
            ovf_o <= push && full;
            unf_o <= pop_i && empty;
        end
    end

    // pointers meet only when the buffer is empty or full
    ptr_count_agree: assert property (@(posedge clk491520) disable iff (rst_ip)
        (wr_ptr == rd_ptr) == (empty || full));

endmodule

// File: apb_vol_regs.sv
// APB register file: channel volumes, mute control, sticky overflow/underrun flags
`timescale 1ns/1ns
`include "dmix_config.svh"

module apb_vol_regs
    import dmix_pkg::*;
(
    input  logic         clk491520,
    input  logic         rst_ip,
    input  apb_req_t     apb_req_i,
    output apb_rsp_t     apb_rsp_o,
    input  dmix_status_t events_i,
    output vol_cfg_t     vol_cfg_o
);
    localparam logic [`DMIX_VOL_WIDTH-1:0] VOL_UNITY = 1 << `DMIX_VOL_FRAC;

    logic         access;
    logic         wr;
    logic         err;
    logic [31:0]  rdata;
    dmix_status_t sticky_q;
    dmix_status_t clr;

    assign access = apb_req_i.psel && apb_req_i.penable;
    assign wr = access && apb_req_i.pwrite && !err;

    always_comb begin
        err = 1'b0;
        rdata = '0;
        case (reg_addr_e'(apb_req_i.paddr))
            VOL_L: rdata = vol_cfg_o.vol_l;
            VOL_R: rdata = vol_cfg_o.vol_r;
            CTRL: rdata = {31'b0, vol_cfg_o.mute};
            STATUS: begin
                rdata = {30'b0, sticky_q};
                // clearing nothing is refused
                err = apb_req_i.pwrite && (apb_req_i.pwdata[1:0] == 2'b00);
            end
            default: err = 1'b1;
        endcase
    end

    // zero wait states, failed accesses read zero
    assign apb_rsp_o.prdata = (access && !apb_req_i.pwrite && !err) ? rdata : '0;
    assign apb_rsp_o.pready = 1'b1;
    assign apb_rsp_o.pslverr = access && err;

    assign clr = (wr && reg_addr_e'(apb_req_i.paddr) == STATUS) ?
                 dmix_status_t'(apb_req_i.pwdata[1:0]) : '0;

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            vol_cfg_o.vol_l <= VOL_UNITY;
            vol_cfg_o.vol_r <= VOL_UNITY;
            vol_cfg_o.mute <= 1'b0;
            sticky_q <= '0;
        end else begin
            if (wr) begin
                case (reg_addr_e'(apb_req_i.paddr))
                    VOL_L: vol_cfg_o.vol_l <= apb_req_i.pwdata;
                    VOL_R: vol_cfg_o.vol_r <= apb_req_i.pwdata;
                    CTRL: vol_cfg_o.mute <= apb_req_i.pwdata[0];
                    default: ;
                endcase
            end
            // a new event beats a clear in the same cycle
            sticky_q <= events_i | (sticky_q & ~clr);
        end
    end

    penable_with_psel: assert property (@(posedge clk491520) disable iff (rst_ip)
        apb_req_i.penable |-> apb_req_i.psel);

endmodule

// File: vol_mixer.sv
// volume pipeline: Q8.24 multiply per channel, then shift, saturation, mute
`timescale 1ns/1ns
`include "dmix_config.svh"

module vol_mixer
    import dmix_pkg::*;
(
    input  logic     clk491520,
    input  logic     rst_ip,
    input  logic     pop_i,
    output logic     ack_o,
    output frame_t   frame_o,
    output logic     fifo_pop_o,
    input  logic     fifo_ack_i,
    input  frame_t   fifo_frame_i,
    input  vol_cfg_t vol_cfg_i
);
    localparam int PW = 24 + `DMIX_VOL_WIDTH + 1;
    localparam logic signed [PW-1:0] S_MAX = 2 ** 23 - 1;
    localparam logic signed [PW-1:0] S_MIN = -(2 ** 23);

    logic signed [PW-1:0] prod_l_q;
    logic signed [PW-1:0] prod_r_q;
    logic                 valid_q;
    logic                 mute_q;

    // volume is unsigned, so widen it with a zero sign bit
    function automatic logic signed [PW-1:0] scale(
        input logic signed [23:0]          s,
        input logic [`DMIX_VOL_WIDTH-1:0] v
    );
        logic signed [`DMIX_VOL_WIDTH:0] gain;
        gain = signed'({1'b0, v});
        return s * gain;
    endfunction

    function automatic logic signed [23:0] sat24(input logic signed [PW-1:0] p);
        logic signed [PW-1:0] q;
        q = p >>> `DMIX_VOL_FRAC;
        if (q > S_MAX) begin
            return S_MAX[23:0];
        end else if (q < S_MIN) begin
            return S_MIN[23:0];
        end
        return q[23:0];
    endfunction

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            fifo_pop_o <= 1'b0;
            ack_o <= 1'b0;
        end else begin
            fifo_pop_o <= pop_i;
            ack_o <= fifo_ack_i;
        end
    end

    // stage one: products, with valid and mute captured alongside
    always_ff @(posedge clk491520) begin
        if (fifo_ack_i) begin
            prod_l_q <= scale(fifo_frame_i.left, vol_cfg_i.vol_l);
            prod_r_q <= scale(fifo_frame_i.right, vol_cfg_i.vol_r);
            valid_q <= fifo_frame_i.valid;
            mute_q <= vol_cfg_i.mute;
        end
    end

    // stage two
    always_comb begin
        frame_o.valid = valid_q;
        if (valid_q && !mute_q) begin
            frame_o.left = sat24(prod_l_q);
            frame_o.right = sat24(prod_r_q);
        end else begin
            frame_o.left = '0;
            frame_o.right = '0;
        end
    end

    fifo_ack_latency: assert property (@(posedge clk491520) disable iff (rst_ip)
        fifo_pop_o |=> fifo_ack_i);

endmodule

// File: i2s_dac_drv.sv
// I2S DAC driver: bck, lrck and MSB-first serial data, one frame request per word clock
`timescale 1ns/1ns
`include "dmix_config.svh"

module i2s_dac_drv
    import dmix_pkg::*;
(
    input  logic   clk491520,
    input  logic   rst_ip,
    output logic   pop_o,
    input  logic   ack_i,
    input  frame_t frame_i,
    output logic   bck_o,
    output logic   lrck_o,
    output logic   data_o
);
    localparam int DIV = `DMIX_BCK_DIV;
    localparam int DW = $clog2(DIV);
    localparam int POS_W = $clog2(64 * DIV) + 1;
    // request goes out this many cycles before the frame boundary
    localparam int POP_LEAD = 16;
    localparam int POP_POS = 64 * DIV - POP_LEAD - 1;

    typedef enum logic [1:0] {IDLE, LEFT, RIGHT} dac_state_e;

    dac_state_e       state_q;
    logic [DW-1:0]    div_q;
    logic [DW-1:0]    div_nxt;
    logic [4:0]       bit_q;
    logic [POS_W-1:0] pos;
    logic             bck_end;
    logic             ch_end;
    logic             frame_load;
    logic             right_load;
    logic [23:0]      sr_q;
    logic [23:0]      hold_r_q;
    frame_t           nxt_q;
    logic             pend_q;

    assign bck_end = (div_q == DW'(DIV - 1));
    assign ch_end = bck_end && (bit_q == 5'd31);
    assign div_nxt = bck_end ? '0 : div_q + 1'b1;
    // cycle index within the stereo frame
    assign pos = ((state_q == RIGHT) ? POS_W'(32 * DIV) : '0) + POS_W'(bit_q * DIV)
                 + POS_W'(div_q);
    assign frame_load = (state_q == IDLE) || (ch_end && state_q == RIGHT);
    assign right_load = ch_end && (state_q == LEFT);

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            state_q <= IDLE;
            div_q <= '0;
            bit_q <= '0;
        end else begin
            case (state_q)
                IDLE: state_q <= LEFT;
                LEFT: state_q <= ch_end ? RIGHT : LEFT;
                RIGHT: state_q <= ch_end ? LEFT : RIGHT;
                default: state_q <= IDLE;
            endcase
            if (state_q != IDLE) begin
                div_q <= div_nxt;
                if (bck_end) begin
                    bit_q <= bit_q + 1'b1;
                end
            end
        end
    end

    // shift register empties to zeros after 24 bits, giving the padding
    always_ff @(posedge clk491520) begin
        if (frame_load) begin
            sr_q <= nxt_q.left;
            hold_r_q <= nxt_q.right;
        end else if (right_load) begin
            sr_q <= hold_r_q;
        end else if (bck_end) begin
            sr_q <= {sr_q[22:0], 1'b0};
        end
    end

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            bck_o <= 1'b0;
            lrck_o <= 1'b0;
            data_o <= 1'b0;
            pop_o <= 1'b0;
            pend_q <= 1'b0;
            nxt_q <= '0;
        end else begin
            bck_o <= (state_q != IDLE) && (div_nxt >= DW'(DIV / 2));
            if (ch_end) begin
                lrck_o <= (state_q == LEFT);
            end
            // slot 0 of each channel is the one-bck delay
            if (frame_load || right_load) begin
                data_o <= 1'b0;
            end else if (bck_end) begin
                data_o <= sr_q[23];
            end
            pop_o <= (state_q != IDLE) && (pos == POS_W'(POP_POS));
            if (pop_o) begin
                pend_q <= 1'b1;
            end else if (ack_i) begin
                pend_q <= 1'b0;
            end
            if (ack_i) begin
                nxt_q <= frame_i;
            end
        end
    end

    ack_needs_pop: assert property (@(posedge clk491520) disable iff (rst_ip)
        ack_i |-> pend_q);

endmodule

// File: dmix_core.sv
// top level: frame FIFO, volume pipeline, APB register file and I2S DAC driver
`timescale 1ns/1ns

module dmix_core
    import dmix_pkg::*;
(
    input  logic     clk491520,
    input  logic     rst_ip,
    input  logic     in_ack_i,
    input  sample_t  in_sample_i,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,
    output logic     bck_o,
    output logic     lrck_o,
    output logic     data_o
);
    logic              fifo_pop;
    logic              fifo_ack;
    frame_t            fifo_frame;
    logic              mix_pop;
    logic              mix_ack;
    frame_t            mix_frame;
    vol_cfg_t          vol_cfg;
    wire dmix_status_t fifo_events;

    frame_fifo fifo_i (
        .clk491520  (clk491520),
        .rst_ip     (rst_ip),
        .in_ack_i   (in_ack_i),
        .in_sample_i(in_sample_i),
        .pop_i      (fifo_pop),
        .ack_o      (fifo_ack),
        .frame_o    (fifo_frame),
        .ovf_o      (fifo_events.overflow),
        .unf_o      (fifo_events.underrun)
    );

    vol_mixer mixer_i (
        .clk491520   (clk491520),
        .rst_ip      (rst_ip),
        .pop_i       (mix_pop),
        .ack_o       (mix_ack),
        .frame_o     (mix_frame),
        .fifo_pop_o  (fifo_pop),
        .fifo_ack_i  (fifo_ack),
        .fifo_frame_i(fifo_frame),
        .vol_cfg_i   (vol_cfg)
    );

    apb_vol_regs regs_i (
        .clk491520(clk491520),
        .rst_ip   (rst_ip),
        .apb_req_i(apb_req_i),
        .apb_rsp_o(apb_rsp_o),
        .events_i (fifo_events),
        .vol_cfg_o(vol_cfg)
    );

    i2s_dac_drv dac_i (
        .clk491520(clk491520),
        .rst_ip   (rst_ip),
        .pop_o    (mix_pop),
        .ack_i    (mix_ack),
        .frame_i  (mix_frame),
        .bck_o    (bck_o),
        .lrck_o   (lrck_o),
        .data_o   (data_o)
    );

endmodule

// File: tb_dmix.sv
// testbench for dmix_core: stim file replay, APB access, I2S deserializer, compare tasks, timeout
`timescale 1ns/1ns
`include "dmix_config.svh"

module tb_dmix
    import dmix_pkg::*;
;
    localparam int FRAME_CYCLES = 64 * `DMIX_BCK_DIV;
    localparam int MAX_RECS = 128;

    logic     clk491520 = 1'b0;
    logic     rst_ip;
    logic     in_ack;
    sample_t  in_sample;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     bck_o;
    logic     lrck_o;
    logic     data_o;

    logic [31:0] stim [0:4*MAX_RECS-1];
    frame_t      exp_q[$];
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_base = 0;
    int          cycles = 0;
    int          limit = 0;
    int          periods;
    int          rec;
    logic        done;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    apb_rsp_t    rsp;
    logic [23:0] rnd_l;
    logic [23:0] rnd_r;
    logic [31:0] vol_l_sh;
    logic [31:0] vol_r_sh;
    logic        mute_sh;
    logic [31:0] lcg_state = 32'h3050_873a;
    int          slot = -1;
    logic        last_lrck = 1'b0;
    logic [23:0] shift_l;
    logic [23:0] shift_r;

    dmix_core dut_i (
        .clk491520  (clk491520),
        .rst_ip     (rst_ip),
        .in_ack_i   (in_ack),
        .in_sample_i(in_sample),
        .apb_req_i  (apb_req),
        .apb_rsp_o  (apb_rsp),
        .bck_o      (bck_o),
        .lrck_o     (lrck_o),
        .data_o     (data_o)
    );

    always #10 clk491520 = ~clk491520;

    always @(posedge clk491520) begin
        cycles <= cycles + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // Q8.24 gain, arithmetic shift, clip to 24-bit rails
    function automatic logic signed [23:0] gain_model(input logic signed [23:0] s,
                                                      input logic [31:0] vol,
                                                      input logic mute);
        longint prod;
        if (mute) begin
            return '0;
        end
        prod = longint'(s) * longint'(vol);
        prod = prod >>> `DMIX_VOL_FRAC;
        if (prod > 64'sd8388607) begin
            return 24'h7fffff;
        end else if (prod < -64'sd8388608) begin
            return 24'h800000;
        end
        return prod[23:0];
    endfunction

    function automatic frame_t make_frame(input logic [23:0] l, input logic [23:0] r);
        frame_t f;
        f.valid = 1'b1;
        f.left = l;
        f.right = r;
        return f;
    endfunction

    function automatic apb_rsp_t make_rsp(input logic [31:0] d, input logic err);
        apb_rsp_t r;
        r.prdata = d;
        r.pready = 1'b1;
        r.pslverr = err;
        return r;
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1: return "registers";
            2: return "unity passthrough";
            3: return "scaling and saturation";
            4: return "mute";
            5: return "underrun";
            6: return "overflow";
            default: return "unnamed";
        endcase
    endfunction

    task automatic cmp_frame(input string sig, input frame_t exp, input frame_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH at %0t ns: %s expected %h got %h", $time, sig, exp, act);
        end
    endtask

    task automatic cmp_apb(input string sig, input apb_rsp_t exp, input apb_rsp_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH at %0t ns: %s expected %h got %h", $time, sig, exp, act);
        end
    endtask

    task automatic cmp_status(input string sig, input dmix_status_t exp,
                              input dmix_status_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH at %0t ns: %s expected %b got %b", $time, sig, exp, act);
        end
    endtask

    // setup and access phase, response taken inside the access phase
    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output apb_rsp_t r);
        @(negedge clk491520);
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = wr;
        apb_req.paddr = addr;
        apb_req.pwdata = wdata;
        @(negedge clk491520);
        apb_req.penable = 1'b1;
        #1;
        r = apb_rsp;
        @(negedge clk491520);
        apb_req = '0;
    endtask

    task automatic track_write(input logic [3:0] addr, input logic [31:0] data);
        case (addr)
            `DMIX_REG_VOL_L: vol_l_sh = data;
            `DMIX_REG_VOL_R: vol_r_sh = data;
            `DMIX_REG_CTRL: mute_sh = data[0];
            default: ;
        endcase
    endtask

    task automatic push_frame(input logic [23:0] l, input logic [23:0] r);
        @(negedge clk491520);
        in_ack = 1'b1;
        in_sample.word = l;
        in_sample.lrck = 1'b0;
        @(negedge clk491520);
        in_sample.word = r;
        in_sample.lrck = 1'b1;
        @(negedge clk491520);
        in_ack = 1'b0;
        in_sample = '0;
    endtask

    task automatic random_frame(output logic [23:0] l, output logic [23:0] r);
        lcg_state = lcg_next(lcg_state);
        l = lcg_state[31:8];
        lcg_state = lcg_next(lcg_state);
        r = lcg_state[31:8];
    endtask

    // lrck falls where one stereo frame ends and the next begins
    task automatic wait_boundary();
        @(negedge lrck_o);
    endtask

    task automatic expect_scaled(input logic [23:0] l, input logic [23:0] r);
        exp_q.push_back(make_frame(gain_model(l, vol_l_sh, mute_sh),
                                   gain_model(r, vol_r_sh, mute_sh)));
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk491520);
        end
    endtask

    task automatic finish_test(input int num);
        int delta;
        drain();
        delta = errors - test_err_base;
        test_err_base = errors;
        tests_run++;
        if (delta != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s (%0d errors)", num, test_name(num),
                 (delta == 0) ? "ok" : "FAILED", delta);
        // nothing pushed in this period, so the next frame is silence
        exp_q.push_back(make_frame(24'h0, 24'h0));
        wait_boundary();
    endtask

    // I2S receive: slot 0 is the delay bit, slots 1..24 carry the word
    always @(posedge bck_o) begin
        if (lrck_o !== last_lrck) begin
            slot = 0;
        end else begin
            slot = slot + 1;
        end
        last_lrck = lrck_o;
        if (slot >= 1 && slot <= 24) begin
            if (lrck_o) begin
                shift_r = {shift_r[22:0], data_o};
            end else begin
                shift_l = {shift_l[22:0], data_o};
            end
        end
        if (lrck_o && slot == 24) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR at %0t ns: I2S frame received with none expected", $time);
            end else begin
                cmp_frame("i2s frame", exp_q.pop_front(), make_frame(shift_l, shift_r));
            end
        end
    end

    initial begin
        @(posedge clk491520);
        while (cycles < limit) begin
            @(posedge clk491520);
        end
        $display("ERROR: timeout after %0d cycles, the DUT stopped delivering frames", cycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst_ip = 1'b1;
        in_ack = 1'b0;
        in_sample = '0;
        apb_req = '0;
        vol_l_sh = 32'h0100_0000;
        vol_r_sh = 32'h0100_0000;
        mute_sh = 1'b0;
        $readmemh("dmix_stim.txt", stim);

        periods = 0;
        rec = 0;
        while (rec < MAX_RECS && !$isunknown(stim[4*rec]) && stim[4*rec] != 32'hf) begin
            case (stim[4*rec])
                32'h0, 32'h3: periods += 1;
                32'h5, 32'h6: periods += stim[4*rec+1];
                32'h7: periods += `DMIX_FIFO_DEPTH;
                default: ;
            endcase
            rec++;
        end
        limit = (periods + 4) * FRAME_CYCLES + 1000;

        // the first frame after reset is silence
        exp_q.push_back(make_frame(24'h0, 24'h0));
        repeat (5) @(posedge clk491520);
        @(negedge clk491520);
        rst_ip = 1'b0;

        rec = 0;
        done = 1'b0;
        while (!done) begin
            op = stim[4*rec];
            a = stim[4*rec+1];
            b = stim[4*rec+2];
            c = stim[4*rec+3];
            rec++;
            if ($isunknown(op) || rec >= MAX_RECS) begin
                errors++;
                $display("ERROR: stimulus file ends without an end record");
                done = 1'b1;
            end else begin
                case (op)
                    32'h0: finish_test(a);
                    32'h1: begin
                        apb_xfer(1'b1, a[3:0], b, rsp);
                        cmp_apb("apb_rsp_o", make_rsp(32'h0, c[0]), rsp);
                        if (!c[0]) begin
                            track_write(a[3:0], b);
                        end
                    end
                    32'h2: begin
                        apb_xfer(1'b0, a[3:0], 32'h0, rsp);
                        cmp_apb("apb_rsp_o", make_rsp(b, c[0]), rsp);
                    end
                    32'h3: begin
                        push_frame(a[23:0], b[23:0]);
                        wait_boundary();
                    end
                    32'h4: exp_q.push_back(make_frame(a[23:0], b[23:0]));
                    32'h5: repeat (a) begin
                        random_frame(rnd_l, rnd_r);
                        push_frame(rnd_l, rnd_r);
                        expect_scaled(rnd_l, rnd_r);
                        wait_boundary();
                    end
                    32'h6: repeat (a) begin
                        exp_q.push_back(make_frame(24'h0, 24'h0));
                        wait_boundary();
                    end
                    32'h7: begin
                        // only the first FIFO-depth frames of a burst survive
                        for (int i = 0; i < a; i++) begin
                            random_frame(rnd_l, rnd_r);
                            push_frame(rnd_l, rnd_r);
                            if (i < `DMIX_FIFO_DEPTH) begin
                                expect_scaled(rnd_l, rnd_r);
                            end
                        end
                        repeat (`DMIX_FIFO_DEPTH) wait_boundary();
                    end
                    32'h8: begin
                        apb_xfer(1'b0, `DMIX_REG_STATUS, 32'h0, rsp);
                        if (rsp.pslverr) begin
                            errors++;
                            $display("ERROR at %0t ns: STATUS read returned pslverr", $time);
                        end
                        cmp_status("STATUS", dmix_status_t'(a[1:0]),
                                   dmix_status_t'(rsp.prdata[1:0]));
                    end
                    32'hf: done = 1'b1;
                    default: begin
                        errors++;
                        $display("ERROR: unknown stimulus record kind %h", op);
                        done = 1'b1;
                    end
                endcase
            end
        end
        drain();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: dmix_stim.txt
// columns (hex): kind arg0 arg1 arg2
// 1 APB write addr data pslverr, 2 APB read addr data pslverr, 3 input frame left right,
// 4 expected frame left right, 5 random frames n, 6 idle periods n, 7 burst n,
// 8 STATUS read bits, 0 end of test n, f end of file
2 0 01000000 0
2 4 01000000 0
2 8 0 0
8 0 0 0
1 0 00abcdef 0
2 0 00abcdef 0
1 4 12345678 0
2 4 12345678 0
1 8 1 0
2 8 1 0
1 8 0 0
2 2 0 1
1 6 5 1
1 c 0 1
1 0 01000000 0
1 4 01000000 0
0 1 0 0
3 123456 876543 0
4 123456 876543 0
3 7fffff 800000 0
4 7fffff 800000 0
5 3 0 0
0 2 0 0
1 0 00800000 0
1 4 02000000 0
3 100000 500000 0
4 080000 7fffff 0
3 fffff1 fffff1 0
4 fffff8 ffffe2 0
5 2 0 0
1 0 7f000000 0
1 4 7f000000 0
3 7fffff 800000 0
4 7fffff 800000 0
3 000010 fffff0 0
4 0007f0 fff810 0
1 0 01000000 0
1 4 01000000 0
0 3 0 0
1 8 1 0
2 8 1 0
3 123456 654321 0
4 0 0 0
5 1 0 0
1 8 0 0
1 0 00800000 0
1 4 00800000 0
3 200000 e00000 0
4 100000 f00000 0
5 2 0 0
1 0 01000000 0
1 4 01000000 0
0 4 0 0
1 c 3 0
8 0 0 0
5 2 0 0
8 0 0 0
6 2 0 0
8 2 0 0
1 c 2 0
8 0 0 0
5 1 0 0
0 5 0 0
1 c 3 0
8 0 0 0
7 6 0 0
8 1 0 0
1 c 1 0
8 0 0 0
5 1 0 0
0 6 0 0
f 0 0 0

// File: all.f
+incdir+.
dmix_pkg.sv
frame_fifo.sv
apb_vol_regs.sv
vol_mixer.sv
i2s_dac_drv.sv
dmix_core.sv
tb_dmix.sv

// File: Bender.yml
package:
  name: dmix

sources:
  - include_dirs:
      - .
    files:
      - dmix_pkg.sv
      - frame_fifo.sv
      - apb_vol_regs.sv
      - vol_mixer.sv
      - i2s_dac_drv.sv
      - dmix_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dmix.sv
